// ==== include/asg_params.svh ====
/*
 * width parameters for one signal generator channel
 * included by the package and by any module that sizes storage or fields
 */
`ifndef ASG_PARAMS_SVH
`define ASG_PARAMS_SVH

// pointer integer part, also the table address width
`define ASG_CWM 10
// pointer fraction bits
`define ASG_CWF 16

// burst length and repetition counters
`define ASG_CWL 32
`define ASG_CWN 16

// sample width and CPU byte address width
`define ASG_DW  16
`define ASG_BAW (`ASG_CWM+2)

`endif

// ==== rtl/asg_pkg.sv ====
/*
 * shared types for the signal generator channel
 * modules pull these in with a wildcard import in their header
 */
`include "asg_params.svh"

package asg_pkg;

  // one table sample
  typedef logic [`ASG_DW-1:0]          asg_data_t;

  // fixed point pointer, also size, step and offset
  typedef logic [`ASG_CWM+`ASG_CWF-1:0] asg_ptr_t;

  // table word address
  typedef logic [`ASG_CWM-1:0]         asg_addr_t;

  // CPU byte address
  typedef logic [`ASG_BAW-1:0]         asg_bus_addr_t;

  // burst counters
  typedef logic [`ASG_CWL-1:0]         asg_bln_t;
  typedef logic [`ASG_CWN-1:0]         asg_bnm_t;

  // sequencer states
  typedef enum logic [1:0] {
    st_idle,
    st_data,
    st_hold
  } asg_state_t;

endpackage

// ==== rtl/asg_table.sv ====
/*
 * sample table for one channel
 * CPU side writes and reads words with a one cycle acknowledge,
 * stream side reads through a registered address and registered data
 */
`timescale 1ns/1ps
`include "asg_params.svh"

module asg_table import asg_pkg::*; (
  input  logic          sto,
  input  logic          ctl_rst,
  // CPU port
  input  logic          bus_wen,
  input  logic          bus_ren,
  input  asg_bus_addr_t bus_addr,
  input  asg_data_t     bus_wdata,
  output asg_data_t     bus_rdata,
  output logic          bus_ack,
  // stream read side
  input  logic          aen,
  input  asg_addr_t     ptr_addr,
  input  logic          ren,
  output asg_data_t     rdata
);

  ////////////////////////////////////////////////////////////////////////////
  // storage
  ////////////////////////////////////////////////////////////////////////////

  asg_data_t mem [0:2**`ASG_CWM-1];

  // word index from byte address
  asg_addr_t bus_widx;
  // stream address register
  asg_addr_t raddr;

  assign bus_widx = bus_addr[2 +: `ASG_CWM];

  ////////////////////////////////////////////////////////////////////////////
  // CPU access
  ////////////////////////////////////////////////////////////////////////////

  // write port and registered readback
  always_ff @(posedge sto) begin
    if (bus_wen) begin
      mem[bus_widx] <= bus_wdata;
    end
    if (bus_ren) begin
      bus_rdata <= mem[bus_widx];
    end
  end

  // ack one cycle after any request
  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      bus_ack <= 1'b0;
    end else begin
      bus_ack <= bus_wen | bus_ren;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stream read
  ////////////////////////////////////////////////////////////////////////////

  // address stage, follows the pointer while stepping
  always_ff @(posedge sto) begin
    if (aen) begin
      raddr <= ptr_addr;
    end
  end

  // data stage, holds the last sample while ren is low
  always_ff @(posedge sto) begin
    if (ren) begin
      rdata <= mem[raddr];
    end
  end

  // every request is acknowledged on the following cycle
  a_bus_ack: assert property (@(posedge sto) disable iff (ctl_rst)
    (bus_wen || bus_ren) |=> bus_ack);

endmodule

// ==== rtl/asg_pointer.sv ====
/*
 * fixed point read pointer for periodic playback
 * loads the phase offset on a start or new period, then steps with
 * modulo wrap at the table size; the integer part addresses the table
 */
`timescale 1ns/1ps
`include "asg_params.svh"

module asg_pointer import asg_pkg::*; (
  input  logic      sto,
  input  logic      ctl_rst,
  // pipeline advance
  input  logic      adv,
  // sequencer controls
  input  logic      trg_hit,
  input  logic      aen,
  // configuration
  input  asg_ptr_t  cfg_siz,
  input  asg_ptr_t  cfg_ste,
  input  asg_ptr_t  cfg_off,
  // integer part to the table
  output asg_addr_t ptr_addr
);

  // full pointer width
  localparam int unsigned PW = `ASG_CWM + `ASG_CWF;

  ////////////////////////////////////////////////////////////////////////////
  // next value arithmetic
  ////////////////////////////////////////////////////////////////////////////

  // current position
  asg_ptr_t        ptr_cur;
  // cur + step + 1, one carry bit
  logic [PW:0]     ptr_sum;
  // sum - (size + 1), extra sign bit on top
  logic [PW+1:0]   ptr_dif;
  logic            ptr_neg;
  asg_ptr_t        ptr_nxt;

  assign ptr_sum = {1'b0, ptr_cur} + {1'b0, cfg_ste} + (PW+1)'(1);
  assign ptr_dif = {1'b0, ptr_sum} - ({2'b00, cfg_siz} + (PW+2)'(1));
  assign ptr_neg = ptr_dif[PW+1];

  // wrap only once the sum reaches the table length
  assign ptr_nxt = ptr_neg ? ptr_sum[PW-1:0] : ptr_dif[PW-1:0];

  ////////////////////////////////////////////////////////////////////////////
  // pointer register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      ptr_cur <= '0;
    end else if (adv) begin
      // start or new period restarts at the phase offset
      if (trg_hit) begin
        ptr_cur <= cfg_off;
      end else if (aen) begin
        ptr_cur <= ptr_nxt;
      end
    end
  end

  // table address is the integer field
  assign ptr_addr = ptr_cur[`ASG_CWF +: `ASG_CWM];

  // after a step the pointer lies inside the table
  a_ptr_range: assert property (@(posedge sto) disable iff (ctl_rst)
    (adv && aen && !trg_hit) |=> (ptr_cur <= cfg_siz));

endmodule

// ==== rtl/asg_sequencer.sv ====
/*
 * playback sequencer: trigger handling, periodic and burst modes
 * burst mode sends bdl+1 stepped samples, holds the last one until the
 * period of bln+1 beats ends, and repeats bnm+1 times or without end
 */
`timescale 1ns/1ps

module asg_sequencer import asg_pkg::*; (
  input  logic      sto,
  input  logic      ctl_rst,
  // pipeline advance
  input  logic      adv,
  // trigger strobe
  input  logic      ctl_trg,
  // burst configuration
  input  logic      cfg_ben,
  input  logic      cfg_inf,
  input  asg_addr_t cfg_bdl,
  input  asg_bln_t  cfg_bln,
  input  asg_bnm_t  cfg_bnm,
  // controls to pointer, table and output stages
  output logic      trg_hit,
  output logic      aen,
  output logic      run,
  output logic      lst_req,
  // events and status
  output logic      evn_per,
  output logic      sts_run,
  output asg_bln_t  sts_bln,
  output asg_bnm_t  sts_bnm
);

  ////////////////////////////////////////////////////////////////////////////
  // counter end flags
  ////////////////////////////////////////////////////////////////////////////

  asg_state_t state;

  logic end_bdl;
  logic end_bln;
  logic end_bnm;
  // period boundary while running a burst
  logic rpt;

  // data part done, length counter compared zero extended
  assign end_bdl = (sts_bln == asg_bln_t'(cfg_bdl));
  // period done
  assign end_bln = (sts_bln == cfg_bln);
  // final repetition, never reached in infinite mode
  assign end_bnm = (sts_bnm == cfg_bnm) && !cfg_inf;

  assign run = (state != st_idle);
  assign rpt = run && cfg_ben && end_bln;

  ////////////////////////////////////////////////////////////////////////////
  // outputs
  ////////////////////////////////////////////////////////////////////////////

  // start from idle, or period restart while running
  // further triggers are ignored once running
  assign trg_hit = run ? rpt : ctl_trg;

  // address enable only while the pipeline moves,
  // so the table address register freezes on a stall
  assign aen = (state == st_data) && adv;

  // closing beat of the last period
  assign lst_req = rpt && end_bnm;

  // one pulse per finished period
  assign evn_per = rpt && adv;

  assign sts_run = run;

  ////////////////////////////////////////////////////////////////////////////
  // state machine and counters
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      state   <= st_idle;
      sts_bln <= '0;
      sts_bnm <= '0;
    end else if (adv) begin
      case (state)
        st_idle: begin
          // wait for a trigger
          if (ctl_trg) begin
            state   <= st_data;
            sts_bln <= '0;
            sts_bnm <= '0;
          end
        end
        st_data, st_hold: begin
          // periodic mode just keeps stepping in st_data
          if (cfg_ben) begin
            if (rpt) begin
              sts_bln <= '0;
              if (end_bnm) begin
                state <= st_idle;
              end else begin
                state   <= st_data;
                // counter frozen at zero in infinite mode
                sts_bnm <= sts_bnm + asg_bnm_t'(!cfg_inf);
              end
            end else begin
              sts_bln <= sts_bln + asg_bln_t'(1);
              // data part over, repeat last sample
              if ((state == st_data) && end_bdl) begin
                state <= st_hold;
              end
            end
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // repetition count stays in range for a finite burst
  a_bnm_range: assert property (@(posedge sto) disable iff (ctl_rst)
    !cfg_inf |-> (sts_bnm <= cfg_bnm));

endmodule

// ==== rtl/asg_stream_out.sv ====
/*
 * output stream pipeline, two stages matching the table address and
 * data registers; everything moves when ready is high or nothing is valid
 */
`timescale 1ns/1ps

module asg_stream_out (
  input  logic sto,
  input  logic ctl_rst,
  // stream handshake
  input  logic tready,
  output logic tvalid,
  output logic tlast,
  // from sequencer
  input  logic run,
  input  logic aen,
  input  logic lst_req,
  // pipeline control
  output logic adv,
  output logic ren,
  output logic evn_lst
);

  // first stage valid and read enable
  logic vld_q;
  logic ren_q;

  // advance rule, a stalled beat blocks every stage
  assign adv = tready | ~tvalid;

  // data register loads only on a moving cycle
  assign ren = ren_q & adv;

  ////////////////////////////////////////////////////////////////////////////
  // stage one, lines up with the table address register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      vld_q   <= 1'b0;
      ren_q   <= 1'b0;
      evn_lst <= 1'b0;
    end else if (adv) begin
      vld_q   <= run;
      ren_q   <= aen;
      evn_lst <= lst_req;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stage two, lines up with the table data register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      tvalid <= 1'b0;
      tlast  <= 1'b0;
    end else if (adv) begin
      tvalid <= vld_q;
      tlast  <= evn_lst;
    end
  end

  // a beat waiting for ready keeps its flags, no new address enters behind it
  a_stall_hold: assert property (@(posedge sto) disable iff (ctl_rst)
    (tvalid && !tready) |=> ($stable(tvalid) && $stable(tlast) && !$past(aen)));

endmodule

// ==== rtl/asg.sv ====
/*
 * one channel of the arbitrary signal generator
 * CPU port fills the sample table, a trigger starts playback as a stream
 */
`timescale 1ns/1ps

module asg import asg_pkg::*; (
  input  logic          sto,
  input  logic          ctl_rst,
  input  logic          ctl_trg,
  // periodic configuration
  input  asg_ptr_t      cfg_siz,
  input  asg_ptr_t      cfg_ste,
  input  asg_ptr_t      cfg_off,
  // burst configuration
  input  logic          cfg_ben,
  input  logic          cfg_inf,
  input  asg_addr_t     cfg_bdl,
  input  asg_bln_t      cfg_bln,
  input  asg_bnm_t      cfg_bnm,
  // CPU port
  input  logic          bus_wen,
  input  logic          bus_ren,
  input  asg_bus_addr_t bus_addr,
  input  asg_data_t     bus_wdata,
  output asg_data_t     bus_rdata,
  output logic          bus_ack,
  // stream
  output asg_data_t     tdata,
  output logic          tvalid,
  input  logic          tready,
  output logic          tlast,
  // events and status
  output logic          evn_per,
  output logic          evn_lst,
  output logic          sts_run,
  output asg_bln_t      sts_bln,
  output asg_bnm_t      sts_bnm
);

  ////////////////////////////////////////////////////////////////////////////
  // internal wiring
  ////////////////////////////////////////////////////////////////////////////

  logic      adv;
  logic      trg_hit;
  logic      aen;
  logic      run;
  logic      lst_req;
  logic      ren;
  asg_addr_t ptr_addr;

  // control state
  asg_sequencer u_seq (
    .sto     (sto),
    .ctl_rst (ctl_rst),
    .adv     (adv),
    .ctl_trg (ctl_trg),
    .cfg_ben (cfg_ben),
    .cfg_inf (cfg_inf),
    .cfg_bdl (cfg_bdl),
    .cfg_bln (cfg_bln),
    .cfg_bnm (cfg_bnm),
    .trg_hit (trg_hit),
    .aen     (aen),
    .run     (run),
    .lst_req (lst_req),
    .evn_per (evn_per),
    .sts_run (sts_run),
    .sts_bln (sts_bln),
    .sts_bnm (sts_bnm)
  );

  // read position
  asg_pointer u_ptr (
    .sto      (sto),
    .ctl_rst  (ctl_rst),
    .adv      (adv),
    .trg_hit  (trg_hit),
    .aen      (aen),
    .cfg_siz  (cfg_siz),
    .cfg_ste  (cfg_ste),
    .cfg_off  (cfg_off),
    .ptr_addr (ptr_addr)
  );

  // sample memory, read data is the stream payload
  asg_table u_tbl (
    .sto       (sto),
    .ctl_rst   (ctl_rst),
    .bus_wen   (bus_wen),
    .bus_ren   (bus_ren),
    .bus_addr  (bus_addr),
    .bus_wdata (bus_wdata),
    .bus_rdata (bus_rdata),
    .bus_ack   (bus_ack),
    .aen       (aen),
    .ptr_addr  (ptr_addr),
    .ren       (ren),
    .rdata     (tdata)
  );

  // valid and last pipeline
  asg_stream_out u_out (
    .sto     (sto),
    .ctl_rst (ctl_rst),
    .tready  (tready),
    .tvalid  (tvalid),
    .tlast   (tlast),
    .run     (run),
    .aen     (aen),
    .lst_req (lst_req),
    .adv     (adv),
    .ren     (ren),
    .evn_lst (evn_lst)
  );

endmodule

// ==== dv/asg_tb.sv ====
/*
 * testbench for one signal generator channel
 * loads the table over the CPU port, plays periodic and burst runs and
 * checks every accepted beat against a queue model with assertions
 */
`timescale 1ns/1ps
`include "asg_params.svh"

module asg_tb import asg_pkg::*; ();

  localparam int TBL_N = 2**`ASG_CWM;
  localparam int N_PER = 320;
  localparam int N_BP  = 200;
  // bus, periodic, random stalls at worst about 3x, bursts, resets, margin
  localparam int LIMIT = 2*TBL_N + N_PER + 3*N_BP + 24 + 24 + 26 + 20*6 + 500;

  logic          sto;
  logic          ctl_rst;
  logic          ctl_trg;
  asg_ptr_t      cfg_siz;
  asg_ptr_t      cfg_ste;
  asg_ptr_t      cfg_off;
  logic          cfg_ben;
  logic          cfg_inf;
  asg_addr_t     cfg_bdl;
  asg_bln_t      cfg_bln;
  asg_bnm_t      cfg_bnm;
  logic          bus_wen;
  logic          bus_ren;
  asg_bus_addr_t bus_addr;
  asg_data_t     bus_wdata;
  asg_data_t     bus_rdata;
  logic          bus_ack;
  asg_data_t     tdata;
  logic          tvalid;
  logic          tready;
  logic          tlast;
  logic          evn_per;
  logic          evn_lst;
  logic          sts_run;
  asg_bln_t      sts_bln;
  asg_bnm_t      sts_bnm;

  // model queue and the beat armed for the next edge
  asg_data_t exp_q[$];
  logic      last_q[$];
  asg_data_t exp_data;
  logic      exp_last;
  logic      armed;
  logic      rnd_rdy;
  asg_data_t rd_exp;

  int errs;
  int beats;
  int per_cnt;
  int lst_cnt;
  int cyc;
  int base;

  asg dut0 (.*);

  ////////////////////////////////////////////////////////////////////////////
  // clock, timeout, model
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    sto = 1'b0;
    forever #4 sto = ~sto;
  end

  always @(posedge sto) begin
    cyc <= cyc + 1;
    if (cyc >= LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", LIMIT);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  // table contents, every address bit matters
  function automatic asg_data_t fill(input int unsigned i);
    logic [31:0] v;
    v = (i * 32'h9e37) ^ (i >> 3) ^ 32'h5a5a;
    return v[15:0];
  endfunction

  // sample at step idx, modulo the table length in fixed point
  function automatic asg_data_t sample_at(input int unsigned idx);
    longint unsigned pos;
    pos = (64'(cfg_off) + 64'(idx) * (64'(cfg_ste) + 64'd1)) % (64'(cfg_siz) + 64'd1);
    return fill(32'(pos >> `ASG_CWF));
  endfunction

  // tready on the falling edge, beat to be accepted is popped here
  always @(negedge sto) begin : drive_ready
    logic [31:0] r;
    logic        rdy;
    r   = $urandom;
    rdy = rnd_rdy ? r[0] : 1'b1;
    tready <= rdy;
    if (tvalid && rdy && exp_q.size() != 0) begin
      exp_data <= exp_q.pop_front();
      exp_last <= last_q.pop_front();
      armed    <= 1'b1;
      beats    <= beats + 1;
    end else begin
      armed <= 1'b0;
    end
  end

  // period and last events, read once inputs have settled
  always @(negedge sto) begin
    #1;
    if (evn_per && !ctl_rst) begin
      per_cnt++;
    end
    if (evn_lst && !ctl_rst) begin
      lst_cnt++;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // checking assertions
  ////////////////////////////////////////////////////////////////////////////

  a_data: assert property (@(posedge sto) disable iff (ctl_rst)
    armed |-> (tvalid && tdata == exp_data))
    else begin
      errs++;
      $display("Fail tdata: got %h expected %h", $sampled(tdata), exp_data);
    end

  a_last: assert property (@(posedge sto) disable iff (ctl_rst)
    armed |-> (tlast == exp_last))
    else begin
      errs++;
      $display("Fail tlast: got %h expected %h", $sampled(tlast), exp_last);
    end

  a_hold: assert property (@(posedge sto) disable iff (ctl_rst)
    (tvalid && !tready) |=> (tvalid && $stable(tdata) && $stable(tlast)))
    else begin
      errs++;
      $display("stream output changed while stalled");
    end

  a_ack: assert property (@(posedge sto) disable iff (ctl_rst)
    bus_ack == $past(bus_wen || bus_ren))
    else begin
      errs++;
      $display("bus_ack not exactly one cycle after a request");
    end

  a_rd: assert property (@(posedge sto) disable iff (ctl_rst)
    bus_ren |=> (bus_rdata == $past(rd_exp)))
    else begin
      errs++;
      $display("Fail bus_rdata: got %h expected %h", $sampled(bus_rdata), $past(rd_exp));
    end

  // closing beat flag reaches tlast one stage after evn_lst
  a_lst: assert property (@(posedge sto) disable iff (ctl_rst)
    $rose(tlast) |-> $past(evn_lst))
    else begin
      errs++;
      $display("tlast rose without evn_lst one stage ahead");
    end

  a_inf: assert property (@(posedge sto) disable iff (ctl_rst)
    cfg_inf |-> (sts_bnm == '0))
    else begin
      errs++;
      $display("Fail sts_bnm: got %h expected %h", $sampled(sts_bnm), 16'h0);
    end

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errs++;
      $display("Fail %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic set_cfg(input asg_ptr_t siz, input asg_ptr_t ste, input asg_ptr_t off,
                         input logic ben, input logic inf, input asg_addr_t bdl,
                         input asg_bln_t bln, input asg_bnm_t bnm);
    cfg_siz = siz;
    cfg_ste = ste;
    cfg_off = off;
    cfg_ben = ben;
    cfg_inf = inf;
    cfg_bdl = bdl;
    cfg_bln = bln;
    cfg_bnm = bnm;
  endtask

  task automatic pulse_trigger();
    ctl_trg = 1'b1;
    @(negedge sto);
    ctl_trg = 1'b0;
  endtask

  task automatic push_periodic(input int n);
    for (int k = 0; k < n; k++) begin
      exp_q.push_back(sample_at(k));
      last_q.push_back(1'b0);
    end
  endtask

  // data part steps, gap repeats the last stepped sample
  task automatic push_burst(input int periods, input bit finite);
    int idx;
    for (int p = 0; p < periods; p++) begin
      for (int j = 0; j <= int'(cfg_bln); j++) begin
        idx = (j < int'(cfg_bdl)) ? j : int'(cfg_bdl);
        exp_q.push_back(sample_at(idx));
        last_q.push_back(finite && p == periods - 1 && j == int'(cfg_bln));
      end
    end
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) begin
      @(negedge sto);
    end
    @(negedge sto);
  endtask

  task automatic stop_run();
    ctl_rst = 1'b1;
    repeat (2) @(negedge sto);
    ctl_rst = 1'b0;
    @(negedge sto);
  endtask

  task automatic report(input int num, input string name);
    $display("test %0d %s: done, %0d errors", num, name, errs - base);
    base = errs;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(32'h26ce5ae5));
    errs = 0;
    beats = 0;
    per_cnt = 0;
    lst_cnt = 0;
    cyc = 0;
    base = 0;
    armed = 1'b0;
    rnd_rdy = 1'b0;
    rd_exp = '0;
    exp_data = '0;
    exp_last = 1'b0;
    ctl_rst = 1'b1;
    ctl_trg = 1'b0;
    tready = 1'b1;
    bus_wen = 1'b0;
    bus_ren = 1'b0;
    bus_addr = '0;
    bus_wdata = '0;
    set_cfg('0, '0, '0, 1'b0, 1'b0, '0, '0, '0);
    repeat (4) @(negedge sto);
    ctl_rst = 1'b0;

    // load the table, then read every word back
    for (int i = 0; i < TBL_N; i++) begin
      bus_wen = 1'b1;
      bus_addr = asg_bus_addr_t'(i << 2);
      bus_wdata = fill(i);
      @(negedge sto);
    end
    bus_wen = 1'b0;
    for (int i = 0; i < TBL_N; i++) begin
      bus_ren = 1'b1;
      bus_addr = asg_bus_addr_t'(i << 2);
      rd_exp = fill(i);
      @(negedge sto);
    end
    bus_ren = 1'b0;
    @(negedge sto);
    report(1, "bus readback");

    // periodic, step 3.25 over 1000 entries
    set_cfg(asg_ptr_t'(1000*65536-1), asg_ptr_t'(212991), asg_ptr_t'(360448),
            1'b0, 1'b0, '0, '0, '0);
    push_periodic(N_PER);
    pulse_trigger();
    check_eq("tvalid", 32'(tvalid), 0);
    @(negedge sto);
    check_eq("tvalid", 32'(tvalid), 0);
    @(negedge sto);
    check_eq("tvalid", 32'(tvalid), 1);
    // triggers while running are ignored
    while (exp_q.size() != 0) begin
      ctl_trg = (cyc % 37 == 0);
      @(negedge sto);
    end
    ctl_trg = 1'b0;
    @(negedge sto);
    stop_run();
    report(2, "periodic playback");

    // random back-pressure, step 7.75
    set_cfg(asg_ptr_t'(1000*65536-1), asg_ptr_t'(507903), asg_ptr_t'(794624),
            1'b0, 1'b0, '0, '0, '0);
    rnd_rdy = 1'b1;
    push_periodic(N_BP);
    pulse_trigger();
    wait_drain();
    rnd_rdy = 1'b0;
    stop_run();
    report(3, "back-pressure");

    // finite burst, three periods of eight beats
    set_cfg(asg_ptr_t'(1000*65536-1), asg_ptr_t'(131071), asg_ptr_t'(100*65536),
            1'b1, 1'b0, asg_addr_t'(3), asg_bln_t'(7), asg_bnm_t'(2));
    per_cnt = 0;
    lst_cnt = 0;
    push_burst(3, 1'b1);
    pulse_trigger();
    wait_drain();
    check_eq("tvalid", 32'(tvalid), 0);
    check_eq("sts_run", 32'(sts_run), 0);
    check_eq("evn_per count", 32'(per_cnt), 3);
    check_eq("evn_lst count", 32'(lst_cnt), 1);
    stop_run();
    report(4, "finite burst");

    // infinite burst runs past bnm+1 periods
    set_cfg(asg_ptr_t'(1000*65536-1), asg_ptr_t'(131071), asg_ptr_t'(100*65536),
            1'b1, 1'b1, asg_addr_t'(2), asg_bln_t'(5), asg_bnm_t'(1));
    per_cnt = 0;
    lst_cnt = 0;
    push_burst(4, 1'b0);
    pulse_trigger();
    wait_drain();
    check_eq("sts_run", 32'(sts_run), 1);
    check_eq("evn_per count", 32'(per_cnt), 4);
    check_eq("evn_lst count", 32'(lst_cnt), 0);
    stop_run();
    report(5, "infinite burst");

    // reset in the third period, then a clean restart
    set_cfg(asg_ptr_t'(1000*65536-1), asg_ptr_t'(65535), asg_ptr_t'(200*65536),
            1'b1, 1'b0, asg_addr_t'(1), asg_bln_t'(3), asg_bnm_t'(3));
    push_burst(4, 1'b1);
    while (exp_q.size() > 10) begin
      void'(exp_q.pop_back());
      void'(last_q.pop_back());
    end
    pulse_trigger();
    wait_drain();
    ctl_rst = 1'b1;
    @(negedge sto);
    check_eq("tvalid", 32'(tvalid), 0);
    check_eq("sts_run", 32'(sts_run), 0);
    check_eq("sts_bln", sts_bln, 0);
    check_eq("sts_bnm", 32'(sts_bnm), 0);
    ctl_rst = 1'b0;
    @(negedge sto);
    push_burst(4, 1'b1);
    pulse_trigger();
    wait_drain();
    check_eq("tvalid", 32'(tvalid), 0);
    check_eq("sts_run", 32'(sts_run), 0);
    report(6, "reset mid-run");

    $display("summary: 6 tests, %0d beats checked, %0d errors", beats, errs);
    if (errs == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== asg.f ====
+incdir+include
rtl/asg_pkg.sv
rtl/asg_table.sv
rtl/asg_pointer.sv
rtl/asg_sequencer.sv
rtl/asg_stream_out.sv
rtl/asg.sv
dv/asg_tb.sv

// ==== Makefile ====
# Verilator build and run for the signal generator channel

VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= asg_tb
FLIST     ?= asg.f
MDIR      ?= obj_dir
PASS_MSG  := TEST RESULT: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(MDIR)

run: compile
	./$(MDIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(MDIR)
